// ==== flist.f ====
hdl/leaf_pkg.sv
hdl/leaf_depacketizer.sv
hdl/leaf_in_buffer.sv
hdl/user_kernel.sv
hdl/leaf_route_table.sv
hdl/leaf_packetizer.sv
hdl/leaf.sv
bench/leaf_tb.sv

// ==== Bender.yml ====
package:
  name: leaf

sources:
  - hdl/leaf_pkg.sv
  - hdl/leaf_depacketizer.sv
  - hdl/leaf_in_buffer.sv
  - hdl/user_kernel.sv
  - hdl/leaf_route_table.sv
  - hdl/leaf_packetizer.sv
  - hdl/leaf.sv
  - target: simulation
    files:
      - bench/leaf_tb.sv

// ==== bench/leaf_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaf_tb;

    import leaf_pkg::*;

    // ========================================
    // run length and limits
    // ========================================
    localparam int N_CONFIG    = 7;
    localparam int N_LANE      = 60;
    localparam int N_L4        = 40;
    localparam int N_SEQ       = 130;
    localparam int HOLD_ROUNDS = 6;
    localparam int HOLD_EXTRA  = 10;
    localparam int N_DISCARD   = 20;
    localparam int N_RECHECK   = 8;
    localparam int GAP         = 3;
    localparam int STIM_CYCLES = N_CONFIG * 2 + (N_LANE + N_L4 + N_SEQ + N_RECHECK) * GAP
                               + HOLD_ROUNDS * NUM_IN_PORTS + HOLD_EXTRA + N_DISCARD * 2;
    localparam int CYCLE_LIMIT = 20 * STIM_CYCLES + 200;
    localparam int EXP_DEPTH   = 512;

    logic                     clk;
    logic                     rst;
    logic                     resend;
    leaf_packet_t             din;
    leaf_packet_t             dout;

    // mirror of the route table and of the per-channel sequence counters
    route_t                   route_mirror [1:NUM_OUT_PORTS];
    logic [NUM_ADDR_BITS-1:0] seq_mirror [1:NUM_OUT_PORTS];
    leaf_packet_t             exp_mem [1:NUM_OUT_PORTS][EXP_DEPTH];
    int                       exp_head [1:NUM_OUT_PORTS];
    int                       exp_tail [1:NUM_OUT_PORTS];
    int                       rcv_count [1:NUM_OUT_PORTS];
    logic [31:0]              rng;
    string                    test_name;
    int                       cycle_count;

    leaf dut_i (
        .clk    (clk),
        .rst    (rst),
        .din    (din),
        .dout   (dout),
        .resend (resend)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // kernel transform as seen on each output channel
    function automatic logic [31:0] expected_payload(input int ch, input logic [31:0] w);
        if (ch == 5) begin
            return ~w;
        end
        return w + 32'(ch);
    endfunction

    function automatic leaf_packet_t make_packet(input logic vld, input int port,
                                                 input int addr, input logic [31:0] payload);
        leaf_packet_t p;
        p.vld     = vld;
        p.leaf    = 5'd3;
        p.port    = NUM_PORT_BITS'(port);
        p.addr    = NUM_ADDR_BITS'(addr);
        p.payload = payload;
        return p;
    endfunction

    task automatic fail_now();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_packet(input string name, input leaf_packet_t exp_pkt,
                                input leaf_packet_t act_pkt);
        if (act_pkt !== exp_pkt) begin
            $display("mismatch %s expected %h actual %h", name, exp_pkt, act_pkt);
            fail_now();
        end
    endtask

    task automatic check_count(input string name, input int ch, input int exp_n, input int act_n);
        if (act_n != exp_n) begin
            $display("mismatch %s channel %0d expected %0d actual %0d", name, ch, exp_n, act_n);
            fail_now();
        end
    endtask

    task automatic push_expected(input int ch, input logic [31:0] w);
        leaf_packet_t p;
        p.vld     = 1'b1;
        p.leaf    = route_mirror[ch].leaf;
        p.port    = route_mirror[ch].port;
        p.addr    = seq_mirror[ch];
        p.payload = expected_payload(ch, w);
        exp_mem[ch][exp_tail[ch]] = p;
        exp_tail[ch]++;
        seq_mirror[ch] = seq_mirror[ch] + 1'b1;
    endtask

    task automatic drive_packet(input leaf_packet_t p);
        @(posedge clk);
        #10;
        din = p;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_packet('0);
    endtask

    task automatic next_word(output logic [31:0] w);
        rng = lcg_step(rng);
        w = rng;
    endtask

    // port 4 fans out to channels 4 and 5
    task automatic send_data(input int port, input logic [31:0] w, input int gap);
        drive_packet(make_packet(1'b1, port, 0, w));
        push_expected(port, w);
        if (port == 4) begin
            push_expected(5, w);
        end
        idle_cycles(gap - 1);
    endtask

    task automatic send_config(input int idx, input route_t r);
        drive_packet(make_packet(1'b1, 0, idx, {23'd0, r}));
        if (idx >= 1 && idx <= NUM_OUT_PORTS) begin
            route_mirror[idx] = r;
        end
        idle_cycles(1);
    endtask

    task automatic wait_drain();
        int busy;
        busy = 1;
        while (busy != 0) begin
            @(posedge clk);
            busy = 0;
            for (int c = 1; c <= NUM_OUT_PORTS; c++) begin
                if (exp_head[c] != exp_tail[c]) begin
                    busy = 1;
                end
            end
        end
        idle_cycles(4);
    endtask

    // ========================================
    // output monitor
    // ========================================
    always @(negedge clk) begin : monitor
        int ch;
        if (!rst) begin
            if (resend) begin
                check_packet("resend_hold", '0, dout);
            end else if (!dout.vld) begin
                check_packet("idle_output", '0, dout);
            end else begin
                ch = 0;
                for (int c = 1; c <= NUM_OUT_PORTS; c++) begin
                    if (route_mirror[c].leaf == dout.leaf &&
                        route_mirror[c].port == dout.port) begin
                        ch = c;
                    end
                end
                if (ch == 0) begin
                    $display("packet with leaf %0d port %0d matches no configured channel",
                             dout.leaf, dout.port);
                    fail_now();
                end else if (exp_head[ch] == exp_tail[ch]) begin
                    $display("channel %0d sent a packet when none was expected", ch);
                    fail_now();
                end else begin
                    check_packet(test_name, exp_mem[ch][exp_head[ch]], dout);
                    exp_head[ch]++;
                    rcv_count[ch]++;
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] w;
        int          port;
        int          base4;
        int          base5;
        route_t      r;
        rst       = 1'b1;
        resend    = 1'b0;
        din       = '0;
        rng       = 32'h463453b5;
        test_name = "reset";
        for (int c = 1; c <= NUM_OUT_PORTS; c++) begin
            route_mirror[c] = '0;
            seq_mirror[c]   = '0;
            exp_head[c]     = 0;
            exp_tail[c]     = 0;
            rcv_count[c]    = 0;
        end
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;

        // every channel gets its own leaf and port
        test_name = "route_config";
        for (int c = 1; c <= NUM_OUT_PORTS; c++) begin
            r.leaf = NUM_LEAF_BITS'(c * 5 + 2);
            r.port = NUM_PORT_BITS'(16 - c);
            send_config(c, r);
        end

        test_name = "lane_transform";
        for (int i = 0; i < N_LANE; i++) begin
            next_word(w);
            port = 1 + int'(rng[23:16]) % 3;
            send_data(port, w, GAP);
        end
        wait_drain();

        test_name = "lane4_fanout";
        base4 = rcv_count[4];
        base5 = rcv_count[5];
        for (int i = 0; i < N_L4; i++) begin
            next_word(w);
            send_data(4, w, GAP);
        end
        wait_drain();
        check_count("lane4_fanout", 4, N_L4, rcv_count[4] - base4);
        check_count("lane4_fanout", 5, N_L4, rcv_count[5] - base5);

        // enough words on one channel to wrap the 7-bit address
        test_name = "seq_address";
        for (int i = 0; i < N_SEQ; i++) begin
            next_word(w);
            send_data(1, w, GAP);
        end
        wait_drain();

        test_name = "resend_hold";
        for (int i = 0; i < HOLD_ROUNDS; i++) begin
            // resend rises while the first round is still leaving the packetizer
            if (i == 2) begin
                resend = 1'b1;
            end
            for (int p = 1; p <= NUM_IN_PORTS; p++) begin
                next_word(w);
                send_data(p, w, 1);
            end
        end
        idle_cycles(HOLD_EXTRA);
        @(posedge clk);
        #10;
        resend = 1'b0;
        wait_drain();

        test_name = "discards";
        r.leaf = 5'd31;
        r.port = 4'd0;
        send_config(0, r);
        send_config(6, r);
        for (int i = 0; i < N_DISCARD; i++) begin
            next_word(w);
            if (i % 2 == 0) begin
                drive_packet(make_packet(1'b1, 5 + int'(rng[23:16]) % 11, 0, w));
            end else begin
                drive_packet(make_packet(1'b0, 1 + int'(rng[23:16]) % 4, 0, w));
            end
            idle_cycles(1);
        end
        // every port in turn so that all five routes carry data again
        for (int i = 0; i < N_RECHECK; i++) begin
            next_word(w);
            send_data(1 + i % NUM_IN_PORTS, w, GAP);
        end
        wait_drain();

        for (int c = 1; c <= NUM_OUT_PORTS; c++) begin
            check_count("final_count", c, exp_tail[c], rcv_count[c]);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/leaf.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaf (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire leaf_pkg::leaf_packet_t din,
    output leaf_pkg::leaf_packet_t      dout,
    input  wire logic                   resend
);

    import leaf_pkg::*;

    // depacketizer to input buffers
    logic [NUM_IN_PORTS-1:0]                    wr_en;
    logic [NUM_IN_PORTS-1:0][PAYLOAD_BITS-1:0]  wr_data;
    logic [NUM_IN_PORTS-1:0]                    buf_full;

    // input buffers to kernel
    logic [NUM_IN_PORTS-1:0]                    user_in_vld;
    logic [NUM_IN_PORTS-1:0][PAYLOAD_BITS-1:0]  user_in_data;
    logic [NUM_IN_PORTS-1:0]                    user_in_ack;

    // kernel to packetizer
    logic [NUM_OUT_PORTS-1:0]                   user_out_vld;
    logic [NUM_OUT_PORTS-1:0][PAYLOAD_BITS-1:0] user_out_data;
    logic [NUM_OUT_PORTS-1:0]                   user_out_ack;

    // route table traffic
    logic                                       cfg_we;
    logic [NUM_ADDR_BITS-1:0]                   cfg_idx;
    route_t                                     cfg_route;
    logic [OUT_IDX_BITS-1:0]                    rd_idx;
    route_t                                     rd_route;

    leaf_depacketizer depacketizer_i (
        .clk       (clk),
        .rst       (rst),
        .din       (din),
        .in_vld    (wr_en),
        .in_data   (wr_data),
        .in_full   (buf_full),
        .cfg_we    (cfg_we),
        .cfg_idx   (cfg_idx),
        .cfg_route (cfg_route)
    );

    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : g_in_buf
        leaf_in_buffer in_buffer_i (
            .clk     (clk),
            .rst     (rst),
            .wr_en   (wr_en[i]),
            .wr_data (wr_data[i]),
            .full    (buf_full[i]),
            .vld     (user_in_vld[i]),
            .data    (user_in_data[i]),
            .ack     (user_in_ack[i])
        );
    end

    user_kernel user_kernel_i (
        .clk      (clk),
        .rst      (rst),
        .in_vld   (user_in_vld),
        .in_data  (user_in_data),
        .in_ack   (user_in_ack),
        .out_vld  (user_out_vld),
        .out_data (user_out_data),
        .out_ack  (user_out_ack)
    );

    leaf_route_table route_table_i (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_idx   (cfg_idx),
        .cfg_route (cfg_route),
        .rd_idx    (rd_idx),
        .rd_route  (rd_route)
    );

    leaf_packetizer packetizer_i (
        .clk      (clk),
        .rst      (rst),
        .out_vld  (user_out_vld),
        .out_data (user_out_data),
        .out_ack  (user_out_ack),
        .rd_idx   (rd_idx),
        .rd_route (rd_route),
        .resend   (resend),
        .dout     (dout)
    );

endmodule

`default_nettype wire

// ==== hdl/leaf_packetizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaf_packetizer (
    input  wire logic                                                      clk,
    input  wire logic                                                      rst,
    input  wire logic [leaf_pkg::NUM_OUT_PORTS-1:0]                        out_vld,
    input  wire logic [leaf_pkg::NUM_OUT_PORTS-1:0][leaf_pkg::PAYLOAD_BITS-1:0] out_data,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]                             out_ack,
    output logic [leaf_pkg::OUT_IDX_BITS-1:0]                              rd_idx,
    input  wire leaf_pkg::route_t                                          rd_route,
    input  wire logic                                                      resend,
    output leaf_pkg::leaf_packet_t                                         dout
);

    import leaf_pkg::*;

    logic [OUT_IDX_BITS-1:0]  last_q;
    logic [OUT_IDX_BITS-1:0]  grant_idx;
    logic                     grant_any;
    logic [NUM_ADDR_BITS-1:0] seq_q [NUM_OUT_PORTS];
    leaf_packet_t             pkt_q;
    leaf_packet_t             pkt_next;

    // ========================================
    // round-robin grant
    // ========================================

    // search starts on the channel after the one granted last
    always_comb begin
        int cand;
        grant_any = 1'b0;
        grant_idx = '0;
        for (int n = 1; n <= NUM_OUT_PORTS; n++) begin
            cand = (int'(last_q) + n) % NUM_OUT_PORTS;
            if (!grant_any && out_vld[cand]) begin
                grant_any = 1'b1;
                grant_idx = OUT_IDX_BITS'(cand);
            end
        end
    end

    // nothing is taken from the kernel while the tree asks for a resend
    always_comb begin
        out_ack = '0;
        if (grant_any && !resend) begin
            out_ack[grant_idx] = 1'b1;
        end
    end

    assign rd_idx = grant_idx;

    always_comb begin
        pkt_next.vld     = 1'b1;
        pkt_next.leaf    = rd_route.leaf;
        pkt_next.port    = rd_route.port;
        pkt_next.addr    = seq_q[grant_idx];
        pkt_next.payload = out_data[grant_idx];
    end

    // ========================================
    // output register
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_q  <= leaf_packet_t'({PACKET_BITS{1'b0}});
            last_q <= OUT_IDX_BITS'(NUM_OUT_PORTS - 1);
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                seq_q[i] <= '0;
            end
        end else if (!resend) begin
            if (grant_any) begin
                pkt_q            <= pkt_next;
                last_q           <= grant_idx;
                seq_q[grant_idx] <= seq_q[grant_idx] + 1'b1;
            end else begin
                pkt_q <= '0;
            end
        end
    end

    // the held packet shows again as soon as resend drops
    assign dout = resend ? '0 : pkt_q;

endmodule

`default_nettype wire

// ==== hdl/leaf_route_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaf_route_table (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               cfg_we,
    input  wire logic [leaf_pkg::NUM_ADDR_BITS-1:0] cfg_idx,
    input  wire leaf_pkg::route_t                   cfg_route,
    input  wire logic [leaf_pkg::OUT_IDX_BITS-1:0]  rd_idx,
    output leaf_pkg::route_t                        rd_route
);

    import leaf_pkg::*;

    route_t routes [NUM_OUT_PORTS];

    // config packets number the channels from 1, entries are kept from 0
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                routes[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                if (cfg_we && cfg_idx == NUM_ADDR_BITS'(i + 1)) begin
                    routes[i] <= cfg_route;
                end
            end
        end
    end

    assign rd_route = (rd_idx < OUT_IDX_BITS'(NUM_OUT_PORTS)) ? routes[rd_idx] : '0;

endmodule

`default_nettype wire

// ==== hdl/user_kernel.sv ====
`timescale 1ns/1ps
`default_nettype none

module user_kernel (
    input  wire logic                                                      clk,
    input  wire logic                                                      rst,
    input  wire logic [leaf_pkg::NUM_IN_PORTS-1:0]                         in_vld,
    input  wire logic [leaf_pkg::NUM_IN_PORTS-1:0][leaf_pkg::PAYLOAD_BITS-1:0] in_data,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]                              in_ack,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]                             out_vld,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0][leaf_pkg::PAYLOAD_BITS-1:0] out_data,
    input  wire logic [leaf_pkg::NUM_OUT_PORTS-1:0]                        out_ack
);

    import leaf_pkg::*;

    // ========================================
    // lanes 1 to 3 with one output each
    // ========================================
    for (genvar k = 0; k < NUM_IN_PORTS - 1; k++) begin : g_lane
        logic                    take;
        logic                    lane_vld;
        logic [PAYLOAD_BITS-1:0] lane_data;

        // the register may refill in the cycle its word leaves
        assign take = in_vld[k] && (!lane_vld || out_ack[k]);

        always_ff @(posedge clk) begin
            if (rst) begin
                lane_vld <= 1'b0;
            end else if (take) begin
                lane_vld <= 1'b1;
            end else if (out_ack[k]) begin
                lane_vld <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (take) begin
                lane_data <= in_data[k] + PAYLOAD_BITS'(k + 1);
            end
        end

        assign in_ack[k]   = take;
        assign out_vld[k]  = lane_vld;
        assign out_data[k] = lane_data;
    end

    // ========================================
    // lane 4 fanning out to outputs 4 and 5
    // ========================================
    lane4_state_e            l4_state;
    lane4_state_e            l4_next;
    logic                    l4_take;
    logic [PAYLOAD_BITS-1:0] l4_direct_q;
    logic [PAYLOAD_BITS-1:0] l4_copy_q;

    always_comb begin
        l4_next = l4_state;
        l4_take = 1'b0;
        case (l4_state)
            L4_SEND_BOTH: begin
                if (out_ack[3] && out_ack[4]) begin
                    l4_next = L4_IDLE;
                end else if (out_ack[3]) begin
                    l4_next = L4_WAIT_COPY;
                end else if (out_ack[4]) begin
                    l4_next = L4_WAIT_DIRECT;
                end
            end
            L4_WAIT_DIRECT: begin
                if (out_ack[3]) begin
                    l4_next = L4_IDLE;
                end
            end
            L4_WAIT_COPY: begin
                if (out_ack[4]) begin
                    l4_next = L4_IDLE;
                end
            end
            default: l4_next = l4_state;
        endcase
        // a new word only goes in once both copies of the last one are gone
        if (l4_next == L4_IDLE && in_vld[3]) begin
            l4_take = 1'b1;
            l4_next = L4_SEND_BOTH;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            l4_state <= L4_IDLE;
        end else begin
            l4_state <= l4_next;
        end
    end

    always_ff @(posedge clk) begin
        if (l4_take) begin
            l4_direct_q <= in_data[3] + PAYLOAD_BITS'(4);
            l4_copy_q   <= ~in_data[3];
        end
    end

    assign in_ack[3]   = l4_take;
    assign out_vld[3]  = (l4_state == L4_SEND_BOTH) || (l4_state == L4_WAIT_DIRECT);
    assign out_vld[4]  = (l4_state == L4_SEND_BOTH) || (l4_state == L4_WAIT_COPY);
    assign out_data[3] = l4_direct_q;
    assign out_data[4] = l4_copy_q;

endmodule

`default_nettype wire

// ==== hdl/leaf_in_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaf_in_buffer (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              wr_en,
    input  wire logic [leaf_pkg::PAYLOAD_BITS-1:0] wr_data,
    output logic                                   full,
    output logic                                   vld,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0]      data,
    input  wire logic                              ack
);

    import leaf_pkg::*;

    logic [PAYLOAD_BITS-1:0]     mem [IN_FIFO_DEPTH];
    logic [IN_FIFO_PTR_BITS-1:0] wr_ptr;
    logic [IN_FIFO_PTR_BITS-1:0] rd_ptr;
    logic [IN_FIFO_PTR_BITS:0]   count;
    logic                        push;
    logic                        pop;

    assign full = (count == (IN_FIFO_PTR_BITS+1)'(IN_FIFO_DEPTH));
    assign vld  = (count != '0);
    assign data = mem[rd_ptr];

    assign push = wr_en && !full;
    assign pop  = vld && ack;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/leaf_depacketizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaf_depacketizer (
    input  wire logic                                                  clk,
    input  wire logic                                                  rst,
    input  wire leaf_pkg::leaf_packet_t                                din,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]                          in_vld,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0][leaf_pkg::PAYLOAD_BITS-1:0] in_data,
    input  wire logic [leaf_pkg::NUM_IN_PORTS-1:0]                     in_full,
    output logic                                                       cfg_we,
    output logic [leaf_pkg::NUM_ADDR_BITS-1:0]                         cfg_idx,
    output leaf_pkg::route_t                                           cfg_route
);

    import leaf_pkg::*;

    leaf_packet_t din_q;
    port_kind_e   kind;

    // the tree gives no back-pressure, so every word is taken as it comes
    always_ff @(posedge clk) begin
        if (rst) begin
            din_q <= '0;
        end else begin
            din_q <= din;
        end
    end

    always_comb begin
        if (din_q.port == '0) begin
            kind = PORT_CONFIG;
        end else if (din_q.port <= NUM_PORT_BITS'(NUM_IN_PORTS)) begin
            kind = PORT_DATA;
        end else begin
            kind = PORT_UNUSED;
        end
    end

    // ========================================
    // steering
    // ========================================

    // port 1 feeds buffer 0 and so on, a full buffer loses the word
    always_comb begin
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            in_vld[i] = din_q.vld && (kind == PORT_DATA) &&
                        (din_q.port == NUM_PORT_BITS'(i + 1)) && !in_full[i];
            in_data[i] = din_q.payload;
        end
    end

    // the table itself filters out indices that name no channel
    assign cfg_we    = din_q.vld && (kind == PORT_CONFIG);
    assign cfg_idx   = din_q.addr;
    assign cfg_route = route_t'(din_q.payload[NUM_LEAF_BITS+NUM_PORT_BITS-1:0]);

endmodule

`default_nettype wire

// ==== hdl/leaf_pkg.sv ====
`default_nettype none

package leaf_pkg;

    // ========================================
    // packet geometry
    // ========================================
    localparam int PACKET_BITS   = 49;
    localparam int PAYLOAD_BITS  = 32;
    localparam int NUM_LEAF_BITS = 5;
    localparam int NUM_PORT_BITS = 4;
    localparam int NUM_ADDR_BITS = 7;

    // kernel channel counts and buffer sizing
    localparam int NUM_IN_PORTS     = 4;
    localparam int NUM_OUT_PORTS    = 5;
    localparam int OUT_IDX_BITS     = $clog2(NUM_OUT_PORTS);
    localparam int IN_FIFO_DEPTH    = 8;
    localparam int IN_FIFO_PTR_BITS = $clog2(IN_FIFO_DEPTH);

    // field order matches the tree wire format with vld in the top bit
    typedef struct packed {
        logic                     vld;
        logic [NUM_LEAF_BITS-1:0] leaf;
        logic [NUM_PORT_BITS-1:0] port;
        logic [NUM_ADDR_BITS-1:0] addr;
        logic [PAYLOAD_BITS-1:0]  payload;
    } leaf_packet_t;

    typedef struct packed {
        logic [NUM_LEAF_BITS-1:0] leaf;
        logic [NUM_PORT_BITS-1:0] port;
    } route_t;

    typedef enum logic [1:0] {
        PORT_CONFIG,
        PORT_DATA,
        PORT_UNUSED
    } port_kind_e;

    typedef enum logic [1:0] {
        L4_IDLE,
        L4_SEND_BOTH,
        L4_WAIT_DIRECT,
        L4_WAIT_COPY
    } lane4_state_e;

endpackage

`default_nettype wire
